// ==== design/pcs_params.svh ====
`ifndef PCS_PARAMS_SVH
`define PCS_PARAMS_SVH

// xgmii payload width, lane 0 in the low byte
`define PCS_WORD_BITS 64

// intake buffer depth = credits owned by the source after reset
// must stay a power of two, pointers wrap freely
`define PCS_TX_CREDITS 4

// last gearbox sequence value, the stall beat sits here
`define PCS_GB_MAX 32

// scrambler starting state, all 58 bits set
`define PCS_SCR_SEED 58'h3FFFFFFFFFFFFFF

`endif

// ==== design/pcs_xgmii_pkg.sv ====
`include "pcs_params.svh"

package pcs_xgmii_pkg;

    // one control bit per byte lane
    localparam int XGMII_LANES = `PCS_WORD_BITS / 8;

    // one xgmii beat
    // lane j lives in data[8*j +: 8], flagged by ctl[j]
    typedef struct packed {
        logic [`PCS_WORD_BITS-1:0] data;
        logic [XGMII_LANES-1:0]    ctl;
    } xgmii_word_t;

    // control characters seen on the xgmii side
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hFB;
    localparam logic [7:0] XGMII_TERM  = 8'hFD;
    // error character, sent as an error block like any other bad mix
    localparam logic [7:0] XGMII_ERROR = 8'hFE;

endpackage

// ==== design/pcs_line_pkg.sv ====
`include "pcs_params.svh"

package pcs_line_pkg;

    // 2-bit sync header, never scrambled
    typedef enum logic [1:0] {
        SYNC_DATA = 2'b01,
        SYNC_CTRL = 2'b10
    } sync_hdr_t;

    // block type field, first byte of a control block payload
    typedef enum logic [7:0] {
        BT_CTRL   = 8'h1E,
        BT_START0 = 8'h78,
        BT_TERM0  = 8'h87,
        BT_TERM1  = 8'h99,
        BT_TERM2  = 8'hAA,
        BT_TERM3  = 8'hB4,
        BT_TERM4  = 8'hCC,
        BT_TERM5  = 8'hD2,
        BT_TERM6  = 8'hE1,
        BT_TERM7  = 8'hFF
    } blk_type_t;

    // 66-bit block, payload goes out lsb first
    typedef struct packed {
        sync_hdr_t                 hdr;
        logic [`PCS_WORD_BITS-1:0] payload;
    } line_block_t;

    // terminate type indexed by the lane holding /T/
    localparam blk_type_t BT_TERM [8] = '{
        BT_TERM0, BT_TERM1, BT_TERM2, BT_TERM3,
        BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7
    };

    // 7-bit line control codes
    localparam logic [6:0] LINE_IDLE  = 7'h00;
    localparam logic [6:0] LINE_ERROR = 7'h1E;

    // full control-block payloads
    localparam logic [63:0] IDLE_PAYLOAD  = {{8{LINE_IDLE}}, BT_CTRL};
    localparam logic [63:0] ERROR_PAYLOAD = {{8{LINE_ERROR}}, BT_CTRL};

endpackage

// ==== design/xgmii_word_if.sv ====
`timescale 1ns/1ps
`include "pcs_params.svh"

interface xgmii_word_if;

    import pcs_xgmii_pkg::*;

    // head of the intake buffer
    xgmii_word_t word;
    // buffer holds at least one word
    logic        avail;
    // encoder moves on this beat
    logic        take;
    // one word left the buffer, goes back to the source
    logic        credit;

    // intake buffer side
    modport source (
        output word,
        output avail,
        output credit,
        input  take
    );

    // encoder side
    modport sink (
        input  word,
        input  avail,
        output take
    );

endinterface

// ==== design/tx_credit_intake.sv ====
`timescale 1ns/1ps
`include "pcs_params.svh"

module tx_credit_intake (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_valid,
    input  pcs_xgmii_pkg::xgmii_word_t i_word,
    xgmii_word_if.source               o_word_if
);

    import pcs_xgmii_pkg::*;

    localparam int DEPTH = `PCS_TX_CREDITS;
    localparam int PTR_W = $clog2(DEPTH);

    xgmii_word_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             pop;

    // word leaves only when the encoder moves and something is there
    assign pop = o_word_if.take && o_word_if.avail;

    assign o_word_if.word   = mem[rd_ptr];
    assign o_word_if.avail  = (count != '0);
    // every pop hands one credit back
    assign o_word_if.credit = pop;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave the fill unchanged
            case ({i_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            mem[wr_ptr] <= i_word;
        end
    end

    // source spent a credit it did not own
    a_no_push_when_full: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_valid |-> (count != (PTR_W + 1)'(DEPTH))
    ) else $error("intake push into a full buffer");

endmodule

// ==== design/encode_6466b.sv ====
`timescale 1ns/1ps
`include "pcs_params.svh"

module encode_6466b (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_advance,
    xgmii_word_if.sink                i_word_if,
    output pcs_line_pkg::line_block_t o_block
);

    import pcs_xgmii_pkg::*;
    import pcs_line_pkg::*;

    xgmii_word_t            word;
    logic [XGMII_LANES-1:0] lane_idle;
    logic [XGMII_LANES-1:0] lane_term;
    line_block_t            blk_next;

    // take on every advancing beat, empty buffer turns into idle
    assign i_word_if.take = i_advance;
    assign word           = i_word_if.word;

    // per-lane control character flags
    always_comb begin
        for (int j = 0; j < XGMII_LANES; j++) begin
            lane_idle[j] = word.ctl[j] && (word.data[8*j +: 8] == XGMII_IDLE);
            lane_term[j] = word.ctl[j] && (word.data[8*j +: 8] == XGMII_TERM);
        end
    end

    always_comb begin
        logic [XGMII_LANES-1:0] from_k;
        logic [XGMII_LANES-1:0] after_k;
        logic [63:0]            keep;
        from_k   = '0;
        after_k  = '0;
        keep     = '0;
        // anything unmatched ends up an error block
        blk_next.hdr     = SYNC_CTRL;
        blk_next.payload = ERROR_PAYLOAD;
        if (!i_word_if.avail) begin
            // nothing queued, fill the line with idle
            blk_next.payload = IDLE_PAYLOAD;
        end else if (word.ctl == '0) begin
            blk_next.hdr     = SYNC_DATA;
            blk_next.payload = word.data;
        end else if (&lane_idle) begin
            blk_next.payload = IDLE_PAYLOAD;
        end else if (word.ctl == XGMII_LANES'(1) && word.data[7:0] == XGMII_START) begin
            // /S/ replaced by the type, lanes 1..7 carry data
            blk_next.payload = {word.data[63:8], BT_START0};
        end else begin
            for (int k = 0; k < XGMII_LANES; k++) begin
                // lanes below k data, /T/ in k, idle above
                from_k  = {XGMII_LANES{1'b1}} << k;
                after_k = {XGMII_LANES{1'b1}} << (k + 1);
                keep    = (64'd1 << (8 + 8 * k)) - 64'd1;
                if (word.ctl == from_k && lane_term[k] &&
                        (lane_idle & after_k) == after_k) begin
                    // data bytes follow the type, pad and idle codes are zero
                    blk_next.payload = {word.data[55:0], BT_TERM[k]} & keep;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_block.hdr     <= SYNC_CTRL;
            o_block.payload <= IDLE_PAYLOAD;
        end else if (i_advance) begin
            o_block <= blk_next;
        end
    end

    // only the two legal sync headers ever leave the encoder
    a_hdr_legal: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_block.hdr inside {SYNC_DATA, SYNC_CTRL}
    ) else $error("encoder produced an illegal sync header");

endmodule

// ==== design/tx_scrambler.sv ====
`timescale 1ns/1ps
`include "pcs_params.svh"

module tx_scrambler (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_advance,
    input  pcs_line_pkg::line_block_t i_block,
    output pcs_line_pkg::line_block_t o_block
);

    import pcs_line_pkg::*;

    // x^58 + x^39 + 1, lsb first
    // state[j] is the scrambled bit j+1 places back
    function automatic logic [63:0] scramble(input logic [63:0] din,
                                             input logic [57:0] seed);
        logic [57:0] s;
        logic [63:0] dout;
        s = seed;
        for (int i = 0; i < 64; i++) begin
            dout[i] = din[i] ^ s[38] ^ s[57];
            s       = {s[56:0], dout[i]};
        end
        return dout;
    endfunction

    // state left behind is the last 58 scrambled bits, newest in bit 0
    function automatic logic [57:0] state_after(input logic [63:0] dout);
        logic [57:0] s;
        for (int j = 0; j < 58; j++) begin
            s[j] = dout[63 - j];
        end
        return s;
    endfunction

    // out of reset the register holds an idle block scrambled from the seed
    // and the state carries on from that block
    localparam logic [63:0] RST_PAYLOAD = scramble(IDLE_PAYLOAD, `PCS_SCR_SEED);
    localparam logic [57:0] RST_STATE   = state_after(RST_PAYLOAD);

    logic [57:0] scr_state;
    logic [63:0] scr_payload;

    assign scr_payload = scramble(i_block.payload, scr_state);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            scr_state       <= RST_STATE;
            o_block.hdr     <= SYNC_CTRL;
            o_block.payload <= RST_PAYLOAD;
        end else if (i_advance) begin
            scr_state       <= state_after(scr_payload);
            // header bypasses the scrambler, same delay
            o_block.hdr     <= i_block.hdr;
            o_block.payload <= scr_payload;
        end
    end

endmodule

// ==== design/tx_gearbox_seq.sv ====
`timescale 1ns/1ps
`include "pcs_params.svh"

module tx_gearbox_seq (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  pcs_line_pkg::line_block_t i_block,
    output logic                      o_advance,
    output logic [`PCS_WORD_BITS-1:0] o_tx_data,
    output logic [1:0]                o_tx_header,
    output logic [5:0]                o_tx_sequence
);

    // counter runs one beat ahead of the registered sequence output
    logic [5:0] gb_cnt;

    // pipeline stalls while the counter sits on the last value
    assign o_advance = (gb_cnt != 6'(`PCS_GB_MAX));

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            gb_cnt        <= 6'd1;
            o_tx_sequence <= '0;
        end else begin
            if (gb_cnt == 6'(`PCS_GB_MAX)) begin
                gb_cnt <= '0;
            end else begin
                gb_cnt <= gb_cnt + 6'd1;
            end
            o_tx_sequence <= gb_cnt;
        end
    end

    // data and header load together with the sequence,
    // so the beat showing the last value repeats the one before
    always_ff @(posedge i_clk) begin
        if (o_advance) begin
            o_tx_data   <= i_block.payload;
            o_tx_header <= i_block.hdr;
        end
    end

    a_cnt_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        gb_cnt <= 6'(`PCS_GB_MAX)
    ) else $error("gearbox counter past its limit");

endmodule

// ==== design/pcs_tx.sv ====
`timescale 1ns/1ps
`include "pcs_params.svh"

module pcs_tx (
    input  logic                        xver_tx_clk,
    input  logic                        i_rst_n,
    input  logic                        i_xgmii_valid,
    input  logic [`PCS_WORD_BITS-1:0]   i_xgmii_data,
    input  logic [`PCS_WORD_BITS/8-1:0] i_xgmii_ctl,
    output logic                        o_xgmii_credit,
    output logic [`PCS_WORD_BITS-1:0]   o_xver_tx_data,
    output logic [1:0]                  o_xver_tx_header,
    output logic [5:0]                  o_xver_tx_sequence
);

    import pcs_xgmii_pkg::*;
    import pcs_line_pkg::*;

    xgmii_word_t in_word;
    line_block_t enc_block;
    line_block_t scr_block;
    logic        advance;

    xgmii_word_if word_if ();

    assign in_word.data   = i_xgmii_data;
    assign in_word.ctl    = i_xgmii_ctl;
    assign o_xgmii_credit = word_if.credit;

    // credit-managed intake
    tx_credit_intake u_intake (
        .i_clk     (xver_tx_clk),
        .i_rst_n   (i_rst_n),
        .i_valid   (i_xgmii_valid),
        .i_word    (in_word),
        .o_word_if (word_if.source)
    );

    // 64b/66b encoder
    encode_6466b u_encoder (
        .i_clk     (xver_tx_clk),
        .i_rst_n   (i_rst_n),
        .i_advance (advance),
        .i_word_if (word_if.sink),
        .o_block   (enc_block)
    );

    // payload scrambler
    tx_scrambler u_scrambler (
        .i_clk     (xver_tx_clk),
        .i_rst_n   (i_rst_n),
        .i_advance (advance),
        .i_block   (enc_block),
        .o_block   (scr_block)
    );

    // sequence counter and output registers for the external gearbox
    tx_gearbox_seq u_gearbox (
        .i_clk         (xver_tx_clk),
        .i_rst_n       (i_rst_n),
        .i_block       (scr_block),
        .o_advance     (advance),
        .o_tx_data     (o_xver_tx_data),
        .o_tx_header   (o_xver_tx_header),
        .o_tx_sequence (o_xver_tx_sequence)
    );

endmodule

// ==== tb/pcs_tx_tb.sv ====
`timescale 1ns/1ps
`include "pcs_params.svh"

module pcs_tx_tb;

    import pcs_xgmii_pkg::*;
    import pcs_line_pkg::*;

    localparam int SEED = 32'h5edf8e9d;

    // terminate block types for /T/ in lanes 0..7
    localparam logic [7:0] TERM_TYPES [8] = '{
        8'h87, 8'h99, 8'hAA, 8'hB4, 8'hCC, 8'hD2, 8'hE1, 8'hFF
    };

    typedef enum logic [2:0] {K_DATA, K_IDLE, K_START, K_TERM, K_ERROR} kind_t;

    // one row of the stimulus table
    typedef struct packed {
        xgmii_word_t word;
        kind_t       kind;
        logic [7:0]  exp_type;
        logic [2:0]  lane;
        logic        burst;
    } stim_t;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        i_xgmii_valid;
    logic [63:0] i_xgmii_data;
    logic [7:0]  i_xgmii_ctl;
    logic        o_xgmii_credit;
    logic [63:0] o_xver_tx_data;
    logic [1:0]  o_xver_tx_header;
    logic [5:0]  o_xver_tx_sequence;

    stim_t       stim_q [$];
    line_block_t exp_q [$];
    logic        table_built = 1'b0;
    // source side credit bookkeeping
    int          credits = `PCS_TX_CREDITS;
    int          sent = 0;
    int          returned = 0;
    int          err_block = 0;
    int          err_seq = 0;
    int          err_credit = 0;

    pcs_tx u_dut (
        .xver_tx_clk        (clk),
        .i_rst_n            (rst_n),
        .i_xgmii_valid      (i_xgmii_valid),
        .i_xgmii_data       (i_xgmii_data),
        .i_xgmii_ctl        (i_xgmii_ctl),
        .o_xgmii_credit     (o_xgmii_credit),
        .o_xver_tx_data     (o_xver_tx_data),
        .o_xver_tx_header   (o_xver_tx_header),
        .o_xver_tx_sequence (o_xver_tx_sequence)
    );

    // 4 ns period
    always #2 clk = ~clk;

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    function automatic xgmii_word_t data_word(input logic [63:0] d);
        xgmii_word_t w;
        w.data = d;
        w.ctl  = 8'h00;
        return w;
    endfunction

    function automatic xgmii_word_t idle_word();
        xgmii_word_t w;
        w.data = {8{8'h07}};
        w.ctl  = 8'hFF;
        return w;
    endfunction

    // /S/ in lane 0, data in the rest
    function automatic xgmii_word_t start_word(input logic [63:0] fill);
        xgmii_word_t w;
        w.data = {fill[63:8], 8'hFB};
        w.ctl  = 8'h01;
        return w;
    endfunction

    // data below lane k, /T/ in k, idles above
    function automatic xgmii_word_t term_word(input int k, input logic [63:0] fill);
        xgmii_word_t w;
        w.data = fill;
        w.ctl  = 8'hFF << k;
        w.data[8*k +: 8] = 8'hFD;
        for (int j = k + 1; j < 8; j++) begin
            w.data[8*j +: 8] = 8'h07;
        end
        return w;
    endfunction

    // reference encoder, built from the block format rules
    function automatic line_block_t expected_block(input stim_t s);
        line_block_t b;
        b.hdr     = SYNC_CTRL;
        b.payload = '0;
        case (s.kind)
            K_DATA: begin
                b.hdr     = SYNC_DATA;
                b.payload = s.word.data;
            end
            K_START: begin
                b.payload = {s.word.data[63:8], s.exp_type};
            end
            K_TERM: begin
                // data bytes after the type, pad and idle codes zero
                b.payload[7:0] = s.exp_type;
                for (int j = 0; j < int'(s.lane); j++) begin
                    b.payload[8+8*j +: 8] = s.word.data[8*j +: 8];
                end
            end
            K_ERROR: begin
                b.payload[7:0] = s.exp_type;
                for (int j = 0; j < 8; j++) begin
                    b.payload[8+7*j +: 7] = 7'h1E;
                end
            end
            default: begin
                // idle, eight zero codes
                b.payload[7:0] = s.exp_type;
            end
        endcase
        return b;
    endfunction

    task automatic add_entry(input xgmii_word_t w, input kind_t k, input logic [7:0] t,
                             input int lane, input logic burst);
        stim_t s;
        s.word     = w;
        s.kind     = k;
        s.exp_type = t;
        s.lane     = 3'(lane);
        s.burst    = burst;
        stim_q.push_back(s);
        // idle words vanish among the filler idles
        if (k != K_IDLE) begin
            exp_q.push_back(expected_block(s));
        end
    endtask

    task automatic build_table();
        xgmii_word_t w;
        logic [63:0] fill;
        add_entry(idle_word(), K_IDLE, 8'h1E, 0, 1'b0);
        // one short frame per terminate lane
        for (int k = 0; k < 8; k++) begin
            add_entry(start_word(rand64()), K_START, 8'h78, 0, 1'b0);
            add_entry(data_word(rand64()), K_DATA, 8'h00, 0, 1'b0);
            add_entry(term_word(k, rand64()), K_TERM, TERM_TYPES[k], k, 1'b0);
            add_entry(idle_word(), K_IDLE, 8'h1E, 0, 1'b0);
        end
        // every lane /E/
        w.data = {8{8'hFE}};
        w.ctl  = 8'hFF;
        add_entry(w, K_ERROR, 8'h1E, 0, 1'b0);
        // start in lane 4 is not supported
        fill   = rand64();
        w.data = {fill[63:40], 8'hFB, {4{8'h07}}};
        w.ctl  = 8'h1F;
        add_entry(w, K_ERROR, 8'h1E, 0, 1'b0);
        // ordered set
        w.data = {fill[63:8], 8'h9C};
        w.ctl  = 8'h01;
        add_entry(w, K_ERROR, 8'h1E, 0, 1'b0);
        // terminate followed by /E/ instead of idle
        w = term_word(3, rand64());
        w.data[55:48] = 8'hFE;
        add_entry(w, K_ERROR, 8'h1E, 0, 1'b0);
        // terminate with a control flag on a data lane
        w = term_word(2, rand64());
        w.ctl[0] = 1'b1;
        add_entry(w, K_ERROR, 8'h1E, 0, 1'b0);
        // idle word with one bad control byte
        w = idle_word();
        w.data[39:32] = 8'h00;
        add_entry(w, K_ERROR, 8'h1E, 0, 1'b0);
        // back to back run, one word per beat
        for (int i = 0; i < 16; i++) begin
            add_entry(data_word(rand64()), K_DATA, 8'h00, 0, 1'b1);
        end
        add_entry(start_word(rand64()), K_START, 8'h78, 0, 1'b0);
        add_entry(term_word(7, rand64()), K_TERM, TERM_TYPES[7], 7, 1'b0);
        add_entry(idle_word(), K_IDLE, 8'h1E, 0, 1'b0);
    endtask

    // self-synchronizing descrambler, state holds received bits
    task automatic descramble(input logic [63:0] din, inout logic [57:0] state,
                              output logic [63:0] dout);
        for (int i = 0; i < 64; i++) begin
            dout[i] = din[i] ^ state[38] ^ state[57];
            state   = {state[56:0], din[i]};
        end
    endtask

    task automatic check_block(input line_block_t got, input line_block_t exp,
                               input string what);
        if (got !== exp) begin
            err_block++;
            $display("FAIL %0t: %s got %b/%h expected %b/%h", $time, what,
                     got.hdr, got.payload, exp.hdr, exp.payload);
        end
    endtask

    task automatic check_sequence(input logic [5:0] got, input logic [5:0] exp);
        if (got !== exp) begin
            err_seq++;
            $display("FAIL %0t: sequence got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_credit(input int got, input int exp, input string what);
        if (got != exp) begin
            err_credit++;
            $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // entered and left 0.5 ns after a rising edge
    task automatic send_word(input xgmii_word_t w);
        while (credits == 0) begin
            @(posedge clk);
            #0.5;
        end
        i_xgmii_valid = 1'b1;
        i_xgmii_data  = w.data;
        i_xgmii_ctl   = w.ctl;
        credits--;
        sent++;
        @(posedge clk);
        #0.5;
        i_xgmii_valid = 1'b0;
    endtask

    initial begin : stimulus
        int gap;
        void'($urandom(SEED));
        i_xgmii_valid = 1'b0;
        i_xgmii_data  = '0;
        i_xgmii_ctl   = '0;
        rst_n         = 1'b0;
        build_table();
        table_built = 1'b1;
        repeat (4) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        for (int i = 0; i < stim_q.size(); i++) begin
            gap = stim_q[i].burst ? 0 : int'($urandom_range(3, 0));
            repeat (gap) begin
                @(posedge clk);
                #0.5;
            end
            send_word(stim_q[i].word);
        end
        // a full buffer empties in one beat per word plus one stall beat
        repeat (`PCS_TX_CREDITS + 2) begin
            @(posedge clk);
        end
        check_credit(credits, `PCS_TX_CREDITS, "credits held after input ended");
        check_credit(returned, sent, "credits returned for words sent");
        // remaining blocks still in the pipeline, watchdog bounds this
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        $display("errors: block %0d, sequence %0d, credit %0d", err_block, err_seq, err_credit);
        if (err_block + err_seq + err_credit == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // credit pulses sampled mid-cycle
    initial begin : credit_monitor
        forever begin
            @(negedge clk);
            if (rst_n && o_xgmii_credit) begin
                credits++;
                returned++;
                if (credits > `PCS_TX_CREDITS) begin
                    err_credit++;
                    $display("FAIL %0t: credit returned with no word outstanding", $time);
                end
            end
        end
    end

    initial begin : line_monitor
        line_block_t got;
        line_block_t prev;
        line_block_t plain;
        logic [5:0]  prev_seq;
        logic [57:0] dstate;
        logic        first;
        wait (rst_n);
        @(posedge clk);
        dstate = `PCS_SCR_SEED;
        first  = 1'b1;
        forever begin
            @(negedge clk);
            got.hdr     = sync_hdr_t'(o_xver_tx_header);
            got.payload = o_xver_tx_data;
            if (!first) begin
                check_sequence(o_xver_tx_sequence,
                               (prev_seq == 6'(`PCS_GB_MAX)) ? 6'd0 : prev_seq + 6'd1);
            end
            if (o_xver_tx_sequence == 6'(`PCS_GB_MAX)) begin
                // stall beat repeats the beat before
                check_block(got, prev, "stall beat");
            end else begin
                descramble(got.payload, dstate, plain.payload);
                plain.hdr = got.hdr;
                // filler and idle words are dropped
                if (!(plain.hdr == SYNC_CTRL && plain.payload == 64'h1E)) begin
                    if (exp_q.size() == 0) begin
                        err_block++;
                        $display("block arrived that matches no word sent, at %0t", $time);
                    end else begin
                        check_block(plain, exp_q.pop_front(), "block");
                    end
                end
            end
            prev     = got;
            prev_seq = o_xver_tx_sequence;
            first    = 1'b0;
        end
    end

    initial begin : watchdog
        int limit;
        wait (table_built);
        limit = stim_q.size() * 40 + 200;
        repeat (limit) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", limit);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+design
design/pcs_xgmii_pkg.sv
design/pcs_line_pkg.sv
design/xgmii_word_if.sv
design/tx_credit_intake.sv
design/encode_6466b.sv
design/tx_scrambler.sv
design/tx_gearbox_seq.sv
design/pcs_tx.sv
tb/pcs_tx_tb.sv

// ==== Makefile ====
.PHONY: all sim lint clean

all: sim

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module pcs_tx_tb \
		-Mdir obj_dir -o pcs_tx_sim
	./obj_dir/pcs_tx_sim | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module pcs_tx_tb

clean:
	rm -rf obj_dir sim.log
